//--- filelist.f
+incdir+include
rtl/ami_pkg.sv
rtl/ami_req_queue.sv
rtl/block_req_decode.sv
rtl/block_sector_array.sv
rtl/block_resp_gen.sv
rtl/block_buffer.sv
verif/block_buffer_chk.sv
verif/block_buffer_tb.sv

//--- include/block_buffer_macros.svh
`ifndef BLOCK_BUFFER_MACROS_SVH
`define BLOCK_BUFFER_MACROS_SVH

// Request bus fields
`define BB_ADDR_W        64
`define BB_DATA_W        512
`define BB_SIZE_W        6

// Block geometry, eight 64-bit sectors per 64-byte block
`define BB_NUM_SECTORS   8
`define BB_SECTOR_W      64
`define BB_SECTOR_IDX_W  3

// Tag is the address above the block offset
`define BB_TAG_W         58

// Request queue entries
`define BB_QUEUE_DEPTH   2

`endif

//--- rtl/ami_pkg.sv
`default_nettype none

`include "block_buffer_macros.svh"

package ami_pkg;

    // Request as carried on the request bus
    typedef struct packed {
        logic                   is_write;
        logic [`BB_ADDR_W-1:0]  addr;
        logic [`BB_DATA_W-1:0]  data;
        logic [`BB_SIZE_W-1:0]  size;
    } ami_req_t;

    typedef enum logic [1:0] {
        OP_READ_SECTOR  = 2'd0,
        OP_WRITE_SECTOR = 2'd1,
        OP_WRITE_BLOCK  = 2'd2,
        OP_BAD          = 2'd3
    } bb_op_e;

    typedef enum logic [1:0] {
        ST_OK   = 2'd0,
        ST_MISS = 2'd1,
        ST_BAD  = 2'd2
    } bb_status_e;

    typedef struct packed {
        bb_status_e               status;
        logic [`BB_SECTOR_W-1:0]  data;
    } ami_resp_t;

    // Decoded command shared by execute and result
    typedef struct packed {
        bb_op_e                      op;
        logic                        write_all;
        logic                        write_specific;
        logic [`BB_SECTOR_IDX_W-1:0] sector_idx;
        logic [`BB_TAG_W-1:0]        tag;
        logic [`BB_DATA_W-1:0]       data;
        bb_status_e                  status;
    } bb_cmd_t;

endpackage

`default_nettype wire

//--- rtl/ami_req_queue.sv
`default_nettype none
`timescale 1ns/1ps

`include "block_buffer_macros.svh"

module ami_req_queue (
    input  wire                clk,
    input  wire                rst_n,
    input  wire                req_valid,
    input  wire ami_pkg::ami_req_t req,
    output logic               req_ready,
    output logic               head_valid,
    output ami_pkg::ami_req_t  head,
    input  wire                pop
);

    import ami_pkg::*;

    localparam int DEPTH = `BB_QUEUE_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // Storage holds payload only
    ami_req_t entries [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // Full only when every entry is taken
    assign req_ready  = (count != CNT_W'(DEPTH));
    assign head_valid = (count != '0);
    assign head       = entries[rd_ptr];

    assign push   = req_valid && req_ready;
    assign do_pop = pop && head_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // Accept and pop together keep the count
            case ({push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= req;
        end
    end

endmodule

`default_nettype wire

//--- rtl/block_buffer.sv
`default_nettype none
`timescale 1ns/1ps

`include "block_buffer_macros.svh"

module block_buffer (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     req_valid,
    input  wire ami_pkg::ami_req_t  req,
    output logic                    req_ready,
    output logic                    resp_valid,
    output ami_pkg::ami_resp_t      resp,
    input  wire                     resp_ready
);

    import ami_pkg::*;

    logic                    head_valid;
    ami_req_t                head;
    bb_cmd_t                 cmd;
    logic [`BB_TAG_W-1:0]    tag;
    logic                    tag_valid;
    logic [`BB_SECTOR_W-1:0] rd_sector;
    logic                    issue;

    ami_req_queue u_queue (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req        (req),
        .req_ready  (req_ready),
        .head_valid (head_valid),
        .head       (head),
        .pop        (issue)
    );

    block_req_decode u_decode (
        .head      (head),
        .tag       (tag),
        .tag_valid (tag_valid),
        .cmd       (cmd)
    );

    block_sector_array u_array (
        .clk       (clk),
        .rst_n     (rst_n),
        .issue     (issue),
        .cmd       (cmd),
        .tag       (tag),
        .tag_valid (tag_valid),
        .rd_sector (rd_sector)
    );

    block_resp_gen u_resp (
        .clk        (clk),
        .rst_n      (rst_n),
        .head_valid (head_valid),
        .cmd        (cmd),
        .rd_sector  (rd_sector),
        .issue      (issue),
        .resp_valid (resp_valid),
        .resp       (resp),
        .resp_ready (resp_ready)
    );

endmodule

`default_nettype wire

//--- rtl/block_req_decode.sv
`default_nettype none
`timescale 1ns/1ps

`include "block_buffer_macros.svh"

module block_req_decode (
    input  wire ami_pkg::ami_req_t  head,
    input  wire [`BB_TAG_W-1:0]     tag,
    input  wire                     tag_valid,
    output ami_pkg::bb_cmd_t        cmd
);

    import ami_pkg::*;

    // Size field is log2 of the byte count
    localparam logic [`BB_SIZE_W-1:0] SIZE_SECTOR = `BB_SIZE_W'(3);
    localparam logic [`BB_SIZE_W-1:0] SIZE_BLOCK  = `BB_SIZE_W'(6);
    localparam int OFFSET_W = $clog2(`BB_SECTOR_W / 8);

    logic [`BB_TAG_W-1:0] addr_tag;
    logic                 misaligned;
    logic                 hit;

    assign addr_tag   = head.addr[`BB_ADDR_W-1 -: `BB_TAG_W];
    assign misaligned = (head.addr[OFFSET_W-1:0] != '0);
    assign hit        = tag_valid && (addr_tag == tag);

    always_comb begin
        cmd            = '0;
        cmd.tag        = addr_tag;
        cmd.sector_idx = head.addr[OFFSET_W +: `BB_SECTOR_IDX_W];
        cmd.data       = head.data;

        if (misaligned) begin
            cmd.op = OP_BAD;
        end else begin
            case (head.size)
                SIZE_BLOCK:  cmd.op = OP_WRITE_BLOCK;
                SIZE_SECTOR: cmd.op = head.is_write ? OP_WRITE_SECTOR : OP_READ_SECTOR;
                default:     cmd.op = OP_BAD;
            endcase
        end

        case (cmd.op)
            OP_WRITE_BLOCK: begin
                cmd.write_all = 1'b1;
                cmd.status    = ST_OK;
            end
            OP_WRITE_SECTOR: begin
                // Sector write only lands on a tag hit
                cmd.write_specific = hit;
                cmd.status         = hit ? ST_OK : ST_MISS;
            end
            OP_READ_SECTOR: begin
                cmd.status = hit ? ST_OK : ST_MISS;
            end
            default: begin
                cmd.status = ST_BAD;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/block_resp_gen.sv
`default_nettype none
`timescale 1ns/1ps

`include "block_buffer_macros.svh"

module block_resp_gen (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      head_valid,
    input  wire ami_pkg::bb_cmd_t    cmd,
    input  wire [`BB_SECTOR_W-1:0]   rd_sector,
    output logic                     issue,
    output logic                     resp_valid,
    output ami_pkg::ami_resp_t       resp,
    input  wire                      resp_ready
);

    import ami_pkg::*;

    logic read_ok;

    // Issue when the register is empty or drains this cycle
    assign issue   = head_valid && (!resp_valid || resp_ready);
    assign read_ok = (cmd.op == OP_READ_SECTOR) && (cmd.status == ST_OK);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resp_valid <= 1'b0;
        end else if (issue) begin
            resp_valid <= 1'b1;
        end else if (resp_ready) begin
            resp_valid <= 1'b0;
        end
    end

    // Held until the handshake since loads only happen on issue
    always_ff @(posedge clk) begin
        if (issue) begin
            resp.status <= cmd.status;
            resp.data   <= read_ok ? rd_sector : '0;
        end
    end

endmodule

`default_nettype wire

//--- rtl/block_sector_array.sv
`default_nettype none
`timescale 1ns/1ps

`include "block_buffer_macros.svh"

module block_sector_array (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       issue,
    input  wire ami_pkg::bb_cmd_t     cmd,
    output logic [`BB_TAG_W-1:0]      tag,
    output logic                      tag_valid,
    output logic [`BB_SECTOR_W-1:0]   rd_sector
);

    localparam int NUM = `BB_NUM_SECTORS;
    localparam int SW  = `BB_SECTOR_W;

    logic [NUM-1:0] sector_we;
    logic [SW-1:0]  sectors [NUM];
    logic [SW-1:0]  wr_data [NUM];

    // Write-enable decoder, all sectors or the indexed one
    always_comb begin
        sector_we = '0;
        if (cmd.write_all) begin
            sector_we = '1;
        end else if (cmd.write_specific) begin
            sector_we[cmd.sector_idx] = 1'b1;
        end
    end

    // Block write takes its slice, sector write takes the low 64 bits
    always_comb begin
        for (int i = 0; i < NUM; i++) begin
            wr_data[i] = cmd.write_all ? cmd.data[i*SW +: SW] : cmd.data[SW-1:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM; i++) begin
                sectors[i] <= '0;
            end
        end else if (issue) begin
            for (int i = 0; i < NUM; i++) begin
                if (sector_we[i]) begin
                    sectors[i] <= wr_data[i];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tag       <= '0;
            tag_valid <= 1'b0;
        end else if (issue && cmd.write_all) begin
            tag       <= cmd.tag;
            tag_valid <= 1'b1;
        end
    end

    // Read mux sees contents before this cycle's write
    assign rd_sector = sectors[cmd.sector_idx];

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module block_buffer_tb

out=$(./obj_dir/Vblock_buffer_tb || true)
echo "$out"

if echo "$out" | grep -qx "Simulation completed successfully"; then
    exit 0
else
    exit 1
fi

//--- verif/block_buffer_chk.sv
`default_nettype none
`timescale 1ns/1ps

`include "block_buffer_macros.svh"

module block_buffer_chk #(
    parameter int CNT_W = $clog2(`BB_QUEUE_DEPTH + 1)
) (
    input wire                     clk,
    input wire                     rst_n,
    input wire                     req_valid,
    input wire ami_pkg::ami_req_t  req,
    input wire                     req_ready,
    input wire                     resp_valid,
    input wire ami_pkg::ami_resp_t resp,
    input wire                     resp_ready,
    input wire                     issue
);

    logic [CNT_W-1:0] occupancy;

    // Requests accepted and not yet issued
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            occupancy <= '0;
        end else begin
            occupancy <= occupancy + CNT_W'(req_valid && req_ready) - CNT_W'(issue);
        end
    end

    // Waiting request held by the sender
    assert property (@(posedge clk) disable iff (!rst_n)
        req_valid && !req_ready |=> $stable(req))
        else $error("request changed while waiting for req_ready");

    assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp))
        else $error("response changed or dropped while stalled");

    assert property (@(posedge clk) !rst_n |-> !resp_valid)
        else $error("resp_valid high during reset");

    // A free queue entry means the request port is open
    assert property (@(posedge clk) disable iff (!rst_n)
        occupancy < CNT_W'(`BB_QUEUE_DEPTH) |-> req_ready)
        else $error("req_ready low with a free queue entry");

endmodule

bind block_buffer block_buffer_chk chk_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_valid  (req_valid),
    .req        (req),
    .req_ready  (req_ready),
    .resp_valid (resp_valid),
    .resp       (resp),
    .resp_ready (resp_ready),
    .issue      (issue)
);

`default_nettype wire

//--- verif/block_buffer_tb.sv
`default_nettype none
`timescale 1ns/1ps

`include "block_buffer_macros.svh"

module block_buffer_tb;

    import ami_pkg::*;

    localparam int TIMEOUT = 200;
    localparam logic [`BB_ADDR_W-1:0] BASE_A = 64'h0000_00ab_cdef_0100;
    localparam logic [`BB_ADDR_W-1:0] BASE_B = 64'h0000_0012_3456_7880;

    logic      clk;
    logic      rst_n;
    logic      req_valid;
    ami_req_t  req;
    logic      req_ready;
    logic      resp_valid;
    ami_resp_t resp;
    logic      resp_ready;

    // Reference model of the block and its tag
    logic [`BB_SECTOR_W-1:0] ref_sectors [`BB_NUM_SECTORS] = '{default: '0};
    logic [`BB_TAG_W-1:0]    ref_tag = '0;
    logic                    ref_tag_valid = 1'b0;

    ami_resp_t exp_q [$];
    string     test_name = "reset";
    int        seed = 35;
    int        checks = 0;
    int        errors = 0;

    block_buffer dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [`BB_DATA_W-1:0] rand_block();
        logic [`BB_DATA_W-1:0] d;
        for (int i = 0; i < `BB_DATA_W / 32; i++) begin
            d[i*32 +: 32] = $random(seed);
        end
        return d;
    endfunction

    function automatic logic [`BB_ADDR_W-1:0] sector_addr(input logic [`BB_ADDR_W-1:0] base,
                                                          input int idx);
        return {base[`BB_ADDR_W-1:6], 3'(idx), 3'b000};
    endfunction

    // Applies one request to the model and returns the expected response
    function automatic ami_resp_t model_apply(input ami_req_t r);
        ami_resp_t            rsp;
        logic [`BB_TAG_W-1:0] t;
        int                   idx;
        rsp = '{status: ST_OK, data: '0};
        t   = r.addr[`BB_ADDR_W-1:6];
        idx = int'(r.addr[5:3]);
        if (r.addr[2:0] != 3'b000 || (r.size != 6'd3 && r.size != 6'd6)) begin
            rsp.status = ST_BAD;
        end else if (r.size == 6'd6) begin
            for (int i = 0; i < `BB_NUM_SECTORS; i++) begin
                ref_sectors[i] = r.data[i*`BB_SECTOR_W +: `BB_SECTOR_W];
            end
            ref_tag       = t;
            ref_tag_valid = 1'b1;
        end else if (!ref_tag_valid || ref_tag != t) begin
            rsp.status = ST_MISS;
        end else if (r.is_write) begin
            ref_sectors[idx] = r.data[`BB_SECTOR_W-1:0];
        end else begin
            rsp.data = ref_sectors[idx];
        end
        return rsp;
    endfunction

    task automatic abort(input string msg);
        $display("Timeout in test %s: %s", test_name, msg);
        $display("Simulation failed");
        $finish;
    endtask

    task automatic send(input logic wr, input logic [`BB_ADDR_W-1:0] addr,
                        input logic [`BB_SIZE_W-1:0] size, input logic [`BB_DATA_W-1:0] data);
        ami_req_t r;
        int       t;
        r = '{is_write: wr, addr: addr, data: data, size: size};
        t = 0;
        @(posedge clk);
        req_valid <= 1'b1;
        req       <= r;
        do begin
            @(posedge clk);
            t++;
        end while (!req_ready && t < TIMEOUT);
        if (!req_ready) begin
            abort("request was never accepted");
        end else begin
            req_valid <= 1'b0;
            exp_q.push_back(model_apply(r));
        end
    endtask

    task automatic wait_responses();
        int t;
        t = 0;
        while (exp_q.size() != 0 && t < TIMEOUT) begin
            @(posedge clk);
            t++;
        end
        if (exp_q.size() != 0) begin
            abort("responses did not all arrive");
        end
    endtask

    // Every response handshake is compared in request order
    always @(posedge clk) begin : resp_monitor
        ami_resp_t e;
        if (rst_n && resp_valid && resp_ready) begin
            checks++;
            assert (exp_q.size() != 0) else begin
                errors++;
                $display("Test %s got a response with no request pending", test_name);
            end
            if (exp_q.size() != 0) begin
                e = exp_q.pop_front();
                assert (resp == e) else begin
                    errors++;
                    $display("** Error [%s] expected status %0d data %h, actual status %0d data %h",
                             test_name, e.status, e.data, resp.status, resp.data);
                end
            end
        end
    end

    task automatic read_all(input logic [`BB_ADDR_W-1:0] base);
        for (int i = 0; i < `BB_NUM_SECTORS; i++) begin
            send(1'b0, sector_addr(base, i), 6'd3, '0);
        end
        wait_responses();
    endtask

    task automatic test_miss_before_load();
        test_name = "miss_before_load";
        send(1'b0, sector_addr(BASE_A, 2), 6'd3, '0);
        send(1'b1, sector_addr(BASE_A, 3), 6'd3, rand_block());
        wait_responses();
    endtask

    task automatic test_block_write();
        test_name = "block_write";
        send(1'b1, BASE_A, 6'd6, rand_block());
        read_all(BASE_A);
    endtask

    task automatic test_sector_write();
        test_name = "sector_write";
        send(1'b1, sector_addr(BASE_A, 5), 6'd3, rand_block());
        read_all(BASE_A);
    endtask

    task automatic test_miss_and_bad();
        test_name = "miss_and_bad";
        send(1'b0, sector_addr(BASE_A + 64'h40, 1), 6'd3, '0);
        send(1'b1, sector_addr(BASE_A + 64'h40, 1), 6'd3, rand_block());
        send(1'b0, BASE_A + 64'h4, 6'd3, '0);
        send(1'b1, BASE_A + 64'h2, 6'd6, rand_block());
        send(1'b0, BASE_A, 6'd2, '0);
        send(1'b1, BASE_A, 6'd5, rand_block());
        read_all(BASE_A);
    endtask

    task automatic test_backpressure();
        int sent;
        test_name = "backpressure";
        sent = 0;
        @(posedge clk);
        resp_ready <= 1'b0;
        // Read sector 0, then write sector 6 and read it back
        do begin
            send(sent == 1, sector_addr(BASE_A, (sent == 0) ? 0 : 6), 6'd3, rand_block());
            sent++;
            @(posedge clk);
        end while (req_ready && sent < 6);
        checks++;
        assert (!req_ready) else begin
            errors++;
            $display("Test %s: req_ready stayed high with responses stalled", test_name);
        end
        resp_ready <= 1'b1;
        wait_responses();
    endtask

    task automatic test_tag_replace();
        test_name = "tag_replace";
        send(1'b1, BASE_B, 6'd6, rand_block());
        send(1'b0, sector_addr(BASE_B, 4), 6'd3, '0);
        send(1'b0, sector_addr(BASE_A, 4), 6'd3, '0);
        wait_responses();
    endtask

    initial begin
        rst_n      = 1'b0;
        req_valid  = 1'b0;
        req        = '0;
        resp_ready = 1'b1;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        test_miss_before_load();
        test_block_write();
        test_sector_write();
        test_miss_and_bad();
        test_backpressure();
        test_tag_replace();
        repeat (4) @(posedge clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
